//--- Bender.yml
package:
  name: console_core

sources:
  - logic/core_pkg.sv
  - logic/ctrl_if.sv
  - logic/decode.sv
  - logic/exec.sv
  - logic/mem_stage.sv
  - logic/register_file.sv
  - logic/block_ram.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/core.sv
  - target: simulation
    files:
      - verification/core_tb.sv

//--- build.f
logic/core_pkg.sv
logic/ctrl_if.sv
logic/decode.sv
logic/exec.sv
logic/mem_stage.sv
logic/register_file.sv
logic/block_ram.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/core.sv
verification/core_tb.sv

//--- logic/block_ram.sv
`timescale 1ns/10ps

module block_ram (
    input  logic clk,
    input  logic en,
    input  logic we,
    input  logic [core_pkg::xlen-1:0] addr,
    input  logic [core_pkg::xlen-1:0] wdata,
    output logic [core_pkg::xlen-1:0] rdata
);

    logic [core_pkg::xlen-1:0] mem [core_pkg::ram_words];
    logic [core_pkg::ram_idx_w-1:0] index;

    assign index = addr[core_pkg::ram_idx_w+1:2]; // Word address.

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) mem[index] <= wdata;
            else rdata <= mem[index];
        end
    end

endmodule

//--- logic/core.sv
`timescale 1ns/10ps

module core (
    input  logic clk,
    input  logic rst,
    input  logic uart_input,
    output logic uart_output,
    output logic [core_pkg::xlen-1:0] test
);

    core_pkg::state_e state;
    logic [core_pkg::xlen-1:0] pc;
    logic [core_pkg::xlen-1:0] ram_addr, ram_rdata;
    logic ram_en, ram_we;

    logic [core_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr, wb_addr;
    logic [core_pkg::xlen-1:0] rs1_data, rs2_data, wb_data;
    logic wb_en;

    logic [core_pkg::xlen-1:0] result, store_data, branch_target;
    logic branch_taken, branch;

    logic tx_start, tx_busy;
    logic [7:0] rx_data, in_byte;
    logic rx_valid, use_input;

    ctrl_if ctrl ();

    decode decode_i (
        .clk(clk), .rst(rst), .state(state), .instr(ram_rdata), .ctrl(ctrl),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr)
    );

    exec exec_i (
        .clk(clk), .rst(rst), .state(state), .pc(pc), .ctrl(ctrl),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .result(result),
        .store_data(store_data), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    mem_stage mem_stage_i (
        .clk(clk), .rst(rst), .state(state), .ctrl(ctrl), .load_data(ram_rdata),
        .result(result), .in_byte(in_byte), .use_input(use_input),
        .branch_taken(branch_taken), .wb_en(wb_en), .wb_addr(wb_addr),
        .wb_data(wb_data), .branch(branch)
    );

    register_file register_file_i (
        .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .test(test)
    );

    // Instruction fetch and data access share the single RAM port.
    assign ram_en = (state == core_pkg::st_fetch) || (state == core_pkg::st_memory);
    assign ram_we = (state == core_pkg::st_memory) && ctrl.mem_write;
    assign ram_addr = (state == core_pkg::st_memory) ? result : pc;

    block_ram block_ram_i (
        .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(store_data), .rdata(ram_rdata)
    );

    assign tx_start = (state == core_pkg::st_wait_out) && !tx_busy;

    uart_tx uart_tx_i (
        .clk(clk), .rst(rst), .start(tx_start), .data(rs1_data[7:0]),
        .busy(tx_busy), .tx(uart_output)
    );

    uart_rx uart_rx_i (
        .clk(clk), .rst(rst), .rx(uart_input), .data(rx_data), .valid(rx_valid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= core_pkg::st_fetch;
            pc <= '0;
            use_input <= 1'b0;
        end else begin
            case (state)
                core_pkg::st_fetch: state <= core_pkg::st_decode;
                core_pkg::st_decode: state <= core_pkg::st_execute;
                core_pkg::st_execute: begin
                    use_input <= 1'b0;
                    if (ctrl.data_out) state <= core_pkg::st_wait_out;
                    else if (ctrl.data_in) state <= core_pkg::st_wait_in;
                    else state <= core_pkg::st_memory;
                end
                core_pkg::st_wait_out: begin
                    if (!tx_busy) state <= core_pkg::st_memory; // Start pulses here.
                end
                core_pkg::st_wait_in: begin
                    if (rx_valid) begin
                        use_input <= 1'b1;
                        state <= core_pkg::st_memory;
                    end
                end
                core_pkg::st_memory: state <= core_pkg::st_writeback;
                default: begin
                    pc <= branch ? branch_target : pc + 4;
                    state <= core_pkg::st_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::st_wait_in && rx_valid) in_byte <= rx_data;
    end

endmodule

//--- logic/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    localparam int ram_words = 256;
    localparam int ram_idx_w = $clog2(ram_words);

    localparam int uart_clks_per_bit = 16;
    localparam int uart_cnt_w = $clog2(uart_clks_per_bit);

    // RV32I major opcodes used by the core.
    localparam logic [6:0] op_op = 7'b0110011;
    localparam logic [6:0] op_opimm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_custom0 = 7'b0001011;

    localparam logic [2:0] funct_out = 3'd0; // Console output.
    localparam logic [2:0] funct_in = 3'd1;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_wait_out,
        st_wait_in
    } state_e;

endpackage

//--- logic/ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if;

    logic [core_pkg::xlen-1:0] imm;
    core_pkg::alu_op_e alu_op;
    logic alu_src_imm, alu_pc, branch_eq, branch_ne, jump;
    logic mem_read, mem_write, reg_write;
    logic [core_pkg::reg_addr_w-1:0] rd;
    logic data_out, data_in;

    modport producer (
        output imm, alu_op, alu_src_imm, alu_pc, branch_eq, branch_ne, jump,
        output mem_read, mem_write, reg_write, rd, data_out, data_in
    );

    modport exec_side (
        input imm, alu_op, alu_src_imm, alu_pc, branch_eq, branch_ne, jump
    );

    modport mem_side (
        input rd, reg_write, mem_read
    );

endinterface

//--- logic/decode.sv
`timescale 1ns/10ps

module decode (
    input  logic clk,
    input  logic rst,
    input  core_pkg::state_e state,
    input  logic [core_pkg::xlen-1:0] instr,
    ctrl_if.producer ctrl,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.alu_src_imm <= 1'b0;
            ctrl.alu_pc <= 1'b0;
            ctrl.branch_eq <= 1'b0;
            ctrl.branch_ne <= 1'b0;
            ctrl.jump <= 1'b0;
            ctrl.mem_read <= 1'b0;
            ctrl.mem_write <= 1'b0;
            ctrl.reg_write <= 1'b0;
            ctrl.data_out <= 1'b0;
            ctrl.data_in <= 1'b0;
        end else if (state == core_pkg::st_decode) begin
            rs1_addr <= instr[19:15];
            rs2_addr <= instr[24:20];
            ctrl.rd <= instr[11:7];
            ctrl.imm <= imm_i;
            ctrl.alu_op <= core_pkg::alu_add;
            // Anything not listed below falls through as a no-operation.
            ctrl.alu_src_imm <= 1'b0;
            ctrl.alu_pc <= 1'b0;
            ctrl.branch_eq <= 1'b0;
            ctrl.branch_ne <= 1'b0;
            ctrl.jump <= 1'b0;
            ctrl.mem_read <= 1'b0;
            ctrl.mem_write <= 1'b0;
            ctrl.reg_write <= 1'b0;
            ctrl.data_out <= 1'b0;
            ctrl.data_in <= 1'b0;
            case (opcode)
                core_pkg::op_op: begin
                    ctrl.reg_write <= 1'b1;
                    case (funct3)
                        3'b000: ctrl.alu_op <= instr[30] ? core_pkg::alu_sub : core_pkg::alu_add;
                        3'b010: ctrl.alu_op <= core_pkg::alu_slt;
                        3'b100: ctrl.alu_op <= core_pkg::alu_xor;
                        3'b110: ctrl.alu_op <= core_pkg::alu_or;
                        3'b111: ctrl.alu_op <= core_pkg::alu_and;
                        default: ctrl.reg_write <= 1'b0;
                    endcase
                end
                core_pkg::op_opimm: begin
                    ctrl.alu_src_imm <= 1'b1;
                    ctrl.reg_write <= (funct3 == 3'b000); // ADDI only.
                end
                core_pkg::op_lui: begin
                    ctrl.imm <= imm_u;
                    ctrl.alu_op <= core_pkg::alu_pass_b;
                    ctrl.alu_src_imm <= 1'b1;
                    ctrl.reg_write <= 1'b1;
                end
                core_pkg::op_load: begin
                    ctrl.alu_src_imm <= 1'b1;
                    ctrl.mem_read <= 1'b1;
                    ctrl.reg_write <= 1'b1;
                end
                core_pkg::op_store: begin
                    ctrl.imm <= imm_s;
                    ctrl.alu_src_imm <= 1'b1;
                    ctrl.mem_write <= 1'b1;
                end
                core_pkg::op_branch: begin
                    ctrl.imm <= imm_b;
                    ctrl.branch_eq <= (funct3 == 3'b000);
                    ctrl.branch_ne <= (funct3 == 3'b001);
                end
                core_pkg::op_jal: begin
                    ctrl.imm <= imm_j;
                    ctrl.alu_pc <= 1'b1; // Link value is pc + 4.
                    ctrl.jump <= 1'b1;
                    ctrl.reg_write <= 1'b1;
                end
                core_pkg::op_custom0: begin
                    ctrl.data_out <= (funct3 == core_pkg::funct_out);
                    ctrl.data_in <= (funct3 == core_pkg::funct_in);
                    ctrl.reg_write <= (funct3 == core_pkg::funct_in);
                end
                default: ;
            endcase
        end
    end

endmodule

//--- logic/exec.sv
`timescale 1ns/10ps

module exec (
    input  logic clk,
    input  logic rst,
    input  core_pkg::state_e state,
    input  logic [core_pkg::xlen-1:0] pc,
    ctrl_if.exec_side ctrl,
    input  logic [core_pkg::xlen-1:0] rs1_data,
    input  logic [core_pkg::xlen-1:0] rs2_data,
    output logic [core_pkg::xlen-1:0] result,
    output logic [core_pkg::xlen-1:0] store_data,
    output logic branch_taken,
    output logic [core_pkg::xlen-1:0] branch_target
);

    logic [core_pkg::xlen-1:0] op_a, op_b, alu_out;
    logic equal;

    assign op_a = ctrl.alu_pc ? pc : rs1_data;
    assign op_b = ctrl.jump ? (core_pkg::xlen)'(4) : (ctrl.alu_src_imm ? ctrl.imm : rs2_data);
    assign equal = (rs1_data == rs2_data);

    always_comb begin
        case (ctrl.alu_op)
            core_pkg::alu_add: alu_out = op_a + op_b;
            core_pkg::alu_sub: alu_out = op_a - op_b;
            core_pkg::alu_and: alu_out = op_a & op_b;
            core_pkg::alu_or: alu_out = op_a | op_b;
            core_pkg::alu_xor: alu_out = op_a ^ op_b;
            core_pkg::alu_slt: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branch_taken <= 1'b0;
        end else if (state == core_pkg::st_execute) begin
            branch_taken <= ctrl.jump | (ctrl.branch_eq & equal) | (ctrl.branch_ne & ~equal);
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::st_execute) begin
            result <= alu_out;
            store_data <= rs2_data;
            branch_target <= pc + ctrl.imm; // Branches and JAL are pc relative.
        end
    end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic clk,
    input  logic rst,
    input  core_pkg::state_e state,
    ctrl_if.mem_side ctrl,
    input  logic [core_pkg::xlen-1:0] load_data,
    input  logic [core_pkg::xlen-1:0] result,
    input  logic [7:0] in_byte,
    input  logic use_input,
    input  logic branch_taken,
    output logic wb_en,
    output logic [core_pkg::reg_addr_w-1:0] wb_addr,
    output logic [core_pkg::xlen-1:0] wb_data,
    output logic branch
);

    logic write_q, load_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            write_q <= 1'b0;
            load_q <= 1'b0;
            branch <= 1'b0;
        end else if (state == core_pkg::st_memory) begin
            write_q <= ctrl.reg_write;
            load_q <= ctrl.mem_read;
            branch <= branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::st_memory) wb_addr <= ctrl.rd;
    end

    assign wb_en = write_q && (state == core_pkg::st_writeback);

    // RAM read data arrives in writeback, one cycle after the memory access.
    assign wb_data = load_q ? load_data : use_input ? {24'b0, in_byte} : result;

endmodule

//--- logic/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic clk,
    input  logic rst,
    input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic wb_en,
    input  logic [core_pkg::reg_addr_w-1:0] wb_addr,
    input  logic [core_pkg::xlen-1:0] wb_data,
    output logic [core_pkg::xlen-1:0] rs1_data,
    output logic [core_pkg::xlen-1:0] rs2_data,
    output logic [core_pkg::xlen-1:0] test
);

    logic [core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data; // x0 stays zero.
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign test = regs[10];

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic [7:0] data,
    output logic valid
);

    logic rx_meta, rx_sync, rx_prev;
    logic active;
    logic [3:0] bit_cnt;
    logic [core_pkg::uart_cnt_w-1:0] clk_cnt;
    logic at_sample;

    // The first wait is half a bit so the start bit is sampled in its middle.
    assign at_sample = (bit_cnt == 4'd0) ? (clk_cnt == core_pkg::uart_clks_per_bit / 2 - 1)
                                         : (clk_cnt == core_pkg::uart_clks_per_bit - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
            active <= 1'b0;
            valid <= 1'b0;
            bit_cnt <= '0;
            clk_cnt <= '0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            valid <= 1'b0;
            if (!active) begin
                if (rx_prev && !rx_sync) begin
                    active <= 1'b1;
                    bit_cnt <= '0;
                    clk_cnt <= '0;
                end
            end else if (at_sample) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd0) begin
                    if (rx_sync) active <= 1'b0; // Glitch rather than a start bit.
                    else bit_cnt <= 4'd1;
                end else if (bit_cnt == 4'd9) begin
                    active <= 1'b0;
                    valid <= rx_sync; // Bad stop bit drops the byte.
                end else begin
                    data <= {rx_sync, data[7:1]};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [7:0] data,
    output logic busy,
    output logic tx
);

    logic [8:0] shift; // Data bits then the stop bit.
    logic [3:0] bit_cnt;
    logic [core_pkg::uart_cnt_w-1:0] clk_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            tx <= 1'b1;
            bit_cnt <= '0;
            clk_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                tx <= 1'b0; // Start bit.
                shift <= {1'b1, data};
                bit_cnt <= '0;
                clk_cnt <= '0;
            end
        end else if (clk_cnt == core_pkg::uart_clks_per_bit - 1) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
                tx <= 1'b1;
            end else begin
                tx <= shift[0];
                shift <= shift >> 1;
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

//--- verification/core_tb.sv
`timescale 1ns/10ps

module core_tb;

    logic clk;
    logic rst;
    logic uart_input;
    logic uart_output;
    logic [core_pkg::xlen-1:0] test;

    logic [31:0] prog [$];
    logic [31:0] image [core_pkg::ram_words];
    logic [7:0] in_bytes [$];
    int in_gaps [$];
    logic [7:0] exp_bytes [$];
    logic [7:0] got_bytes [$];
    logic [15:0] lfsr;
    logic [31:0] exp_x10, halt_pc;
    int limit = 100; // Reset and setup slack.
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int errors_before = 0;
    int out_stalls = 0;
    int in_stalls = 0;

    core dut_i (
        .clk(clk), .rst(rst), .uart_input(uart_input), .uart_output(uart_output), .test(test)
    );

    always #4 clk = ~clk;

    function automatic void emit(input logic [31:0] word);
        prog.push_back(word);
    endfunction

    function automatic int here();
        return prog.size() * 4;
    endfunction

    function automatic void addi(input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], 3'b000, rd[4:0], core_pkg::op_opimm});
    endfunction

    function automatic void lui(input int rd, input int imm);
        emit({imm[19:0], rd[4:0], core_pkg::op_lui});
    endfunction

    function automatic void lw(input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], 3'b010, rd[4:0], core_pkg::op_load});
    endfunction

    function automatic void sw(input int rs2, input int rs1, input int imm);
        emit({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], core_pkg::op_store});
    endfunction

    // Kind 0 to 5 is add, sub, and, or, xor, slt.
    function automatic void alu_rr(input int kind, input int rd, input int rs1, input int rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        case (kind)
            0, 1: f3 = 3'b000;
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            4: f3 = 3'b100;
            default: f3 = 3'b010;
        endcase
        f7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
        emit({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], core_pkg::op_op});
    endfunction

    function automatic void branch(input int f3, input int rs1, input int rs2, input int off);
        emit({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
              core_pkg::op_branch});
    endfunction

    function automatic void jal(input int rd, input int off);
        emit({off[20], off[10:1], off[11], off[19:12], rd[4:0], core_pkg::op_jal});
    endfunction

    function automatic void console_out(input int rs1);
        emit({12'b0, rs1[4:0], core_pkg::funct_out, 5'b0, core_pkg::op_custom0});
    endfunction

    function automatic void console_in(input int rd);
        emit({12'b0, 5'b0, core_pkg::funct_in, rd[4:0], core_pkg::op_custom0});
    endfunction

    function automatic void new_program();
        prog.delete();
        in_bytes.delete();
        in_gaps.delete();
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return (32'h9e37_79b9 * (i + 1)) ^ 32'h5a5a_0000;
    endfunction

    // Instruction-set model of the program in image, fed from in_bytes.
    function automatic logic [31:0] model_run(output int steps, output logic [31:0] stop_pc);
        logic [31:0] x [32];
        logic [31:0] m [core_pkg::ram_words];
        logic [31:0] pc, nxt, ins, a, b, addr;
        logic [4:0] rd;
        int in_pos;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < core_pkg::ram_words; i++) m[i] = image[i];
        exp_bytes.delete();
        pc = '0;
        steps = 0;
        in_pos = 0;
        stop_pc = '1;
        while (steps < 4000) begin
            ins = m[pc[9:2]];
            if (ins == {25'b0, core_pkg::op_jal}) begin // Jump to itself.
                stop_pc = pc;
                break;
            end
            steps++;
            rd = ins[11:7];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            nxt = pc + 4;
            case (ins[6:0])
                core_pkg::op_op: begin
                    case ({ins[30], ins[14:12]})
                        4'b0000: x[rd] = a + b;
                        4'b1000: x[rd] = a - b;
                        4'b0111: x[rd] = a & b;
                        4'b0110: x[rd] = a | b;
                        4'b0100: x[rd] = a ^ b;
                        4'b0010: x[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                core_pkg::op_opimm: x[rd] = a + {{20{ins[31]}}, ins[31:20]};
                core_pkg::op_lui: x[rd] = {ins[31:12], 12'b0};
                core_pkg::op_load: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    x[rd] = m[addr[9:2]];
                end
                core_pkg::op_store: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    m[addr[9:2]] = b;
                end
                core_pkg::op_branch: begin
                    if (ins[12] ? (a != b) : (a == b))
                        nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                core_pkg::op_jal: begin
                    x[rd] = pc + 4;
                    nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                core_pkg::op_custom0: begin
                    if (ins[14:12] == core_pkg::funct_out) begin
                        exp_bytes.push_back(a[7:0]);
                    end else if (ins[14:12] == core_pkg::funct_in) begin
                        x[rd] = {24'b0, in_bytes[in_pos]};
                        in_pos++;
                    end
                end
                default: ;
            endcase
            x[0] = '0;
            pc = nxt;
        end
        return x[10];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Drives one 8N1 frame that starts and ends 1 ns after a rising edge.
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_input = frame[i];
            repeat (core_pkg::uart_clks_per_bit) @(posedge clk);
            #1;
        end
    endtask

    task automatic send_inputs();
        @(posedge clk);
        #1;
        for (int i = 0; i < in_bytes.size(); i++) begin
            if (in_gaps[i] > 0) begin
                repeat (in_gaps[i]) @(posedge clk);
                #1;
            end
            send_byte(in_bytes[i]);
        end
    endtask

    always begin : uart_monitor
        logic [7:0] b;
        @(negedge uart_output);
        repeat (core_pkg::uart_clks_per_bit / 2) @(negedge clk); // Middle of the start bit.
        for (int i = 0; i < 8; i++) begin
            repeat (core_pkg::uart_clks_per_bit) @(negedge clk);
            b = {uart_output, b[7:1]};
        end
        repeat (core_pkg::uart_clks_per_bit) @(negedge clk);
        if (uart_output) begin
            got_bytes.push_back(b);
        end else begin
            errors++;
            $display("Error at %0d ns: the core sent a byte with a low stop bit", $time);
        end
    end

    always @(negedge clk) begin
        if (dut_i.state == core_pkg::st_wait_out && dut_i.tx_busy) out_stalls++;
        if (dut_i.state == core_pkg::st_wait_in && !dut_i.rx_valid) in_stalls++;
    end

    task automatic run_test();
        int steps;
        int guard;
        tests++;
        errors_before = errors;
        foreach (image[i]) image[i] = fill_word(i);
        foreach (prog[i]) image[i] = prog[i];
        exp_x10 = model_run(steps, halt_pc);
        limit += 2 * (steps * 5 +
                      (exp_bytes.size() + in_bytes.size()) * 12 * core_pkg::uart_clks_per_bit);
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < core_pkg::ram_words; i++) dut_i.block_ram_i.mem[i] = image[i];
        got_bytes.delete();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        out_stalls = 0;
        in_stalls = 0;
        repeat (4) begin // The first writeback is at the fifth edge.
            @(negedge clk);
            check_value(uart_output, 1'b1, "uart_output after reset");
            check_value(test, '0, "test port after reset");
        end
        fork
            send_inputs();
            while (dut_i.pc !== halt_pc) @(negedge clk);
        join
        guard = 0;
        while (got_bytes.size() < exp_bytes.size() &&
               guard < 12 * core_pkg::uart_clks_per_bit) begin
            @(posedge clk);
            guard++;
        end
        @(negedge clk);
        check_value(got_bytes.size(), exp_bytes.size(), "output byte count");
        for (int i = 0; i < exp_bytes.size() && i < got_bytes.size(); i++)
            check_value(got_bytes[i], exp_bytes[i], $sformatf("output byte %0d", i));
        check_value(test, exp_x10, "x10 on the test port");
    endtask

    task automatic test_done(input string name);
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the core did not finish its programs within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int loop_pc;
        int kind;
        int rd;
        clk = 1'b0;
        rst = 1'b1;
        uart_input = 1'b1;
        lfsr = 16'd90;

        new_program();
        addi(10, 0, 'h5a);
        console_out(10);
        jal(0, 0);
        run_test();
        test_done("reset state");

        new_program();
        addi(1, 0, 100);
        addi(2, 0, -37);
        lui(3, 'h12345);
        addi(3, 3, 'h678);
        alu_rr(0, 4, 1, 2);
        console_out(4);
        alu_rr(1, 5, 2, 1);
        console_out(5);
        alu_rr(2, 6, 3, 5);
        console_out(6);
        alu_rr(3, 7, 3, 2);
        console_out(7);
        alu_rr(4, 8, 6, 7);
        console_out(8);
        alu_rr(5, 9, 2, 1);
        console_out(9);
        alu_rr(5, 11, 1, 2);
        console_out(11);
        alu_rr(0, 10, 3, 8);
        console_out(10);
        jal(0, 0);
        run_test();
        test_done("alu and immediates");

        new_program();
        addi(20, 0, 512); // Data area far above the code.
        addi(1, 0, 'h11);
        lui(2, 'habcde);
        addi(2, 2, 'h22);
        addi(3, 0, -3);
        addi(4, 0, 'h7f);
        sw(1, 20, 0);
        sw(2, 20, 4);
        sw(3, 20, 8);
        sw(4, 20, 12);
        lw(5, 20, 12);
        console_out(5);
        lw(6, 20, 0);
        console_out(6);
        lw(7, 20, 8);
        console_out(7);
        lw(8, 20, 4);
        console_out(8);
        lw(9, 20, 16); // Never written so it still holds the fill pattern.
        console_out(9);
        alu_rr(0, 10, 5, 6);
        alu_rr(0, 10, 10, 7);
        alu_rr(0, 10, 10, 8);
        jal(0, 0);
        run_test();
        test_done("load and store");

        new_program();
        addi(1, 0, 5);
        addi(10, 0, 0);
        loop_pc = here();
        console_out(1);
        addi(10, 10, 3);
        addi(1, 1, -1);
        branch(1, 1, 0, loop_pc - here());
        branch(0, 10, 10, 8);
        console_out(10); // Skipped by the BEQ.
        jal(5, 12);
        addi(10, 0, 99);
        console_out(0);
        console_out(5);
        console_out(10);
        jal(0, 0);
        run_test();
        test_done("control flow");

        new_program();
        addi(10, 0, 0);
        addi(1, 0, 4);
        loop_pc = here();
        console_in(5);
        addi(5, 5, 1);
        console_out(5);
        alu_rr(0, 10, 10, 5);
        addi(1, 1, -1);
        branch(1, 1, 0, loop_pc - here());
        jal(0, 0);
        in_bytes = '{8'h41, 8'h7e, 8'hff, 8'h09};
        in_gaps = '{40, 0, 0, 200}; // Back to back bytes catch the echo still sending.
        run_test();
        check_value(out_stalls > 0, 1'b1, "stalled on a busy transmitter");
        check_value(in_stalls > 0, 1'b1, "stalled waiting for input");
        test_done("console echo");

        new_program();
        for (int i = 0; i < 20; i++) begin
            kind = take_bits(3);
            rd = take_bits(4);
            if (kind >= 6) addi(rd, take_bits(4), take_bits(12));
            else alu_rr(kind, rd, take_bits(4), take_bits(4));
            console_out(rd);
        end
        jal(0, 0);
        run_test();
        test_done("random arithmetic");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
